//--- all.f
+incdir+verilog
verilog/isaPkg.sv
verilog/corePkg.sv
verilog/decoder.sv
verilog/fetchUnit.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/memoryUnit.sv
verilog/core.sv
tests/core_assertions.sv
tests/coreTb.sv

//--- Makefile
# Verilator flow for the core testbench.

.PHONY: help test clean

help:
	@echo "make test   build and run the core testbench with Verilator"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module coreTb -f all.f -o coreSim
	@out=$$(./obj_dir/coreSim); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- tests/coreTb.sv
`timescale 1ns/10ps
`include "core_settings.svh"

`default_nettype none

module coreTb
  import isaPkg::*;
();

  localparam int ImemAw = $clog2(`IMEM_WORDS);
  localparam int TimeoutCycles = 200;
  localparam logic [31:0] Seed = 32'd80812;

  logic              clk;
  logic              reset;
  logic              progWrite;
  logic [ImemAw-1:0] progAddr;
  logic [31:0]       progData;
  logic              start;
  logic [4:0]        dbgRegAddr;
  logic              halted;
  logic              fault;
  logic [31:0]       dbgRegData;

  logic [31:0] prog [$];
  logic [4:0]  expRegs [$];
  logic [31:0] expVals [$];
  logic [31:0] lcgState;
  int          errorCount;
  int          checkCount;

  core dut (
    .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
    .progData(progData), .start(start), .dbgRegAddr(dbgRegAddr), .halted(halted),
    .fault(fault), .dbgRegData(dbgRegData)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ********************************************************************
  // instruction encoders and program building.
  // ********************************************************************
  function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opcOp};
  endfunction

  function automatic logic [31:0] encodeI(input logic [6:0] opc, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opcStore};
  endfunction

  function automatic logic [31:0] encodeB(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
  endfunction

  function automatic logic [31:0] encodeU(input logic [6:0] opc, input logic [19:0] imm,
                                          input logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
  endfunction

  function automatic logic [31:0] encodeAddi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return encodeI(opcOpImm, imm, rs1, 3'b000, rd);
  endfunction

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic void appendInstr(input logic [31:0] instr);
    prog.push_back(instr);
  endfunction

  function automatic void expectReg(input logic [4:0] r, input logic [31:0] value);
    expRegs.push_back(r);
    expVals.push_back(value);
  endfunction

  function automatic void clearProgram();
    prog.delete();
    expRegs.delete();
    expVals.delete();
  endfunction

  // address of the next instruction appended.
  function automatic logic [31:0] currentPc();
    return `RESET_PC + 4 * prog.size();
  endfunction

  // lui rounds up when addi will subtract.
  function automatic void loadConst(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] upper;
    upper = value[31:12] + {19'b0, value[11]};
    appendInstr(encodeU(opcLui, upper, rd));
    appendInstr(encodeAddi(rd, rd, value[11:0]));
  endfunction

  function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ********************************************************************
  // bus tasks and checks.
  // ********************************************************************
  task automatic pulseReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic loadProgram();
    foreach (prog[i]) begin
      @(posedge clk);
      progWrite <= 1'b1;
      progAddr  <= ImemAw'(i);
      progData  <= prog[i];
    end
    @(posedge clk);
    progWrite <= 1'b0;
  endtask

  task automatic pulseStart();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic waitHalt(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!(halted || fault) && cycles < TimeoutCycles);
    assert (halted || fault) else begin
      errorCount++;
      $display("%s: the core did not halt within %0d cycles", name, TimeoutCycles);
    end
  endtask

  task automatic runProgram(input string name);
    pulseReset();
    loadProgram();
    pulseStart();
    waitHalt(name);
  endtask

  task automatic readReg(input logic [4:0] r, output logic [31:0] value);
    @(posedge clk);
    dbgRegAddr <= r;
    @(negedge clk);
    value = dbgRegData;
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkFlags(input string name, input logic expHalted, input logic expFault);
    @(negedge clk);
    checkValue({name, " halted"}, {31'b0, expHalted}, {31'b0, halted});
    checkValue({name, " fault"}, {31'b0, expFault}, {31'b0, fault});
  endtask

  task automatic checkExpected(input string name);
    logic [31:0] value;
    foreach (expRegs[i]) begin
      readReg(expRegs[i], value);
      checkValue($sformatf("%s x%0d", name, expRegs[i]), expVals[i], value);
    end
  endtask

  // ********************************************************************
  // directed tests.
  // ********************************************************************
  task automatic testResetIdle();
    logic [31:0] value;
    clearProgram();
    pulseReset();
    checkFlags("reset idle", 1'b0, 1'b0);
    readReg(5'd0, value);
    checkValue("reset idle x0", 32'd0, value);
    appendInstr(encodeAddi(5'd1, 5'd0, 12'd5));
    appendInstr(encodeAddi(5'd0, 5'd0, 12'd5));
    repeat (4) appendInstr(encodeAddi(5'd0, 5'd0, 12'd0));
    appendInstr(encodeAddi(5'd3, 5'd0, 12'd9));
    appendInstr(EbreakInstr);
    expectReg(5'd1, 32'd5);
    expectReg(5'd0, 32'd0);
    expectReg(5'd3, 32'd9);
    pulseReset();
    loadProgram();
    pulseStart();
    // word 6 has not run yet, so a landed write would change x3.
    @(posedge clk);
    progWrite <= 1'b1;
    progAddr  <= ImemAw'(6);
    progData  <= encodeAddi(5'd3, 5'd0, 12'h055);
    @(posedge clk);
    progWrite <= 1'b0;
    waitHalt("reset idle");
    checkFlags("reset idle run", 1'b1, 1'b0);
    checkExpected("reset idle");
  endtask

  task automatic testArithmetic();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] k;
    logic [31:0] immExt;
    logic [31:0] p;
    logic [4:0]  sh;
    a = nextRand();
    b = nextRand();
    k = nextRand();
    immExt = {{20{k[11]}}, k[11:0]};
    sh = k[16:12];
    clearProgram();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    appendInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    appendInstr(encodeR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
    appendInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b001, 5'd5));
    appendInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b010, 5'd6));
    appendInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b011, 5'd7));
    appendInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
    appendInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b101, 5'd9));
    appendInstr(encodeR(7'h20, 5'd2, 5'd1, 3'b101, 5'd10));
    appendInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b110, 5'd11));
    appendInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b111, 5'd12));
    expectReg(5'd3, a + b);
    expectReg(5'd4, a - b);
    expectReg(5'd5, a << b[4:0]);
    expectReg(5'd6, {31'b0, $signed(a) < $signed(b)});
    expectReg(5'd7, {31'b0, a < b});
    expectReg(5'd8, a ^ b);
    expectReg(5'd9, a >> b[4:0]);
    expectReg(5'd10, $unsigned($signed(a) >>> b[4:0]));
    expectReg(5'd11, a | b);
    expectReg(5'd12, a & b);
    appendInstr(encodeI(opcOpImm, k[11:0], 5'd1, 3'b000, 5'd13));
    appendInstr(encodeI(opcOpImm, k[11:0], 5'd1, 3'b010, 5'd14));
    appendInstr(encodeI(opcOpImm, k[11:0], 5'd1, 3'b011, 5'd15));
    appendInstr(encodeI(opcOpImm, k[11:0], 5'd1, 3'b100, 5'd16));
    appendInstr(encodeI(opcOpImm, k[11:0], 5'd1, 3'b110, 5'd17));
    appendInstr(encodeI(opcOpImm, k[11:0], 5'd1, 3'b111, 5'd18));
    appendInstr(encodeI(opcOpImm, {7'h00, sh}, 5'd1, 3'b001, 5'd19));
    appendInstr(encodeI(opcOpImm, {7'h00, sh}, 5'd1, 3'b101, 5'd20));
    appendInstr(encodeI(opcOpImm, {7'h20, sh}, 5'd1, 3'b101, 5'd21));
    expectReg(5'd13, a + immExt);
    expectReg(5'd14, {31'b0, $signed(a) < $signed(immExt)});
    expectReg(5'd15, {31'b0, a < immExt});
    expectReg(5'd16, a ^ immExt);
    expectReg(5'd17, a | immExt);
    expectReg(5'd18, a & immExt);
    expectReg(5'd19, a << sh);
    expectReg(5'd20, a >> sh);
    expectReg(5'd21, $unsigned($signed(a) >>> sh));
    p = currentPc();
    appendInstr(encodeU(opcAuipc, k[31:12], 5'd22));
    expectReg(5'd22, p + {k[31:12], 12'b0});
    appendInstr(EbreakInstr);
    runProgram("arithmetic");
    checkFlags("arithmetic", 1'b1, 1'b0);
    checkExpected("arithmetic");
  endtask

  task automatic testMemory();
    logic [31:0] base;
    logic [31:0] word;
    logic [31:0] byteSrc;
    logic [31:0] halfSrc;
    logic [31:0] stored;
    base = nextRand() & 32'h0000_0ff0;
    word = nextRand();
    byteSrc = nextRand() | 32'h80;
    halfSrc = nextRand() | 32'h8000;
    // little-endian lanes after the three stores.
    stored = {halfSrc[15:0], byteSrc[7:0], word[7:0]};
    clearProgram();
    loadConst(5'd1, base);
    loadConst(5'd2, word);
    loadConst(5'd3, byteSrc);
    loadConst(5'd4, halfSrc);
    appendInstr(encodeS(12'd0, 5'd2, 5'd1, 3'b010));
    appendInstr(encodeS(12'd1, 5'd3, 5'd1, 3'b000));
    appendInstr(encodeS(12'd2, 5'd4, 5'd1, 3'b001));
    appendInstr(encodeS(12'd8, 5'd2, 5'd1, 3'b010));
    appendInstr(encodeI(opcLoad, 12'd0, 5'd1, 3'b000, 5'd5));
    appendInstr(encodeI(opcLoad, 12'd1, 5'd1, 3'b000, 5'd6));
    appendInstr(encodeI(opcLoad, 12'd1, 5'd1, 3'b100, 5'd7));
    appendInstr(encodeI(opcLoad, 12'd3, 5'd1, 3'b100, 5'd8));
    appendInstr(encodeI(opcLoad, 12'd0, 5'd1, 3'b001, 5'd9));
    appendInstr(encodeI(opcLoad, 12'd2, 5'd1, 3'b001, 5'd10));
    appendInstr(encodeI(opcLoad, 12'd2, 5'd1, 3'b101, 5'd11));
    appendInstr(encodeI(opcLoad, 12'd0, 5'd1, 3'b010, 5'd12));
    appendInstr(encodeI(opcLoad, 12'd8, 5'd1, 3'b010, 5'd13));
    appendInstr(encodeI(opcLoad, 12'd10, 5'd1, 3'b001, 5'd14));
    appendInstr(encodeI(opcLoad, 12'd3, 5'd1, 3'b000, 5'd15));
    appendInstr(encodeAddi(5'd17, 5'd1, 12'd12));
    appendInstr(encodeI(opcLoad, 12'hffc, 5'd17, 3'b010, 5'd16));
    appendInstr(EbreakInstr);
    expectReg(5'd5, {{24{stored[7]}}, stored[7:0]});
    expectReg(5'd6, {{24{stored[15]}}, stored[15:8]});
    expectReg(5'd7, {24'b0, stored[15:8]});
    expectReg(5'd8, {24'b0, stored[31:24]});
    expectReg(5'd9, {{16{stored[15]}}, stored[15:0]});
    expectReg(5'd10, {{16{stored[31]}}, stored[31:16]});
    expectReg(5'd11, {16'b0, stored[31:16]});
    expectReg(5'd12, stored);
    expectReg(5'd13, word);
    expectReg(5'd14, {{16{word[31]}}, word[31:16]});
    expectReg(5'd15, {{24{stored[31]}}, stored[31:24]});
    expectReg(5'd16, word);
    runProgram("memory");
    checkFlags("memory", 1'b1, 1'b0);
    checkExpected("memory");
  endtask

  task automatic testControlFlow();
    logic [4:0]  regA [3];
    logic [4:0]  regB [3];
    logic [31:0] valA [3];
    logic [31:0] valB [3];
    logic [2:0]  f3List [6];
    logic [31:0] mark;
    logic [31:0] p;
    regA = '{5'd4, 5'd3, 5'd4};
    regB = '{5'd5, 5'd4, 5'd3};
    valA = '{32'd1, 32'hffff_ffff, 32'd1};
    valB = '{32'd1, 32'd1, 32'hffff_ffff};
    f3List = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    clearProgram();
    // countdown loop that adds three per pass.
    appendInstr(encodeAddi(5'd1, 5'd0, 12'd5));
    appendInstr(encodeAddi(5'd2, 5'd0, 12'd0));
    appendInstr(encodeAddi(5'd2, 5'd2, 12'd3));
    appendInstr(encodeAddi(5'd1, 5'd1, 12'hfff));
    appendInstr(encodeB(13'h1ff8, 5'd0, 5'd1, 3'b001));
    expectReg(5'd1, 32'd0);
    expectReg(5'd2, 32'd15);
    appendInstr(encodeAddi(5'd3, 5'd0, 12'hfff));
    appendInstr(encodeAddi(5'd4, 5'd0, 12'd1));
    appendInstr(encodeAddi(5'd5, 5'd0, 12'd1));
    // a marker bit is added for each branch not taken.
    for (int f = 0; f < 6; f++) begin
      mark = 32'd0;
      appendInstr(encodeAddi(5'(10 + f), 5'd0, 12'd0));
      for (int q = 0; q < 3; q++) begin
        appendInstr(encodeB(13'd8, regB[q], regA[q], f3List[f]));
        appendInstr(encodeAddi(5'(10 + f), 5'(10 + f), 12'(1 << q)));
        if (!branchTaken(f3List[f], valA[q], valB[q])) mark = mark + (1 << q);
      end
      expectReg(5'(10 + f), mark);
    end
    appendInstr(encodeAddi(5'd23, 5'd0, 12'd7));
    p = currentPc();
    appendInstr(encodeJ(21'd8, 5'd22));
    appendInstr(encodeAddi(5'd23, 5'd0, 12'd1));
    expectReg(5'd22, p + 32'd4);
    expectReg(5'd23, 32'd7);
    appendInstr(encodeAddi(5'd26, 5'd0, 12'd5));
    p = currentPc();
    appendInstr(encodeU(opcAuipc, 20'h0, 5'd24));
    // the odd offset lands on p+12 only when bit 0 is dropped.
    appendInstr(encodeI(opcJalr, 12'd13, 5'd24, 3'b000, 5'd25));
    appendInstr(encodeAddi(5'd26, 5'd0, 12'd1));
    appendInstr(encodeU(opcAuipc, 20'h0, 5'd27));
    appendInstr(EbreakInstr);
    expectReg(5'd24, p);
    expectReg(5'd25, p + 32'd8);
    expectReg(5'd26, 32'd5);
    expectReg(5'd27, p + 32'd12);
    runProgram("control flow");
    checkFlags("control flow", 1'b1, 1'b0);
    checkExpected("control flow");
  endtask

  task automatic testHalting();
    clearProgram();
    appendInstr(encodeAddi(5'd1, 5'd0, 12'd1));
    appendInstr(EbreakInstr);
    appendInstr(encodeAddi(5'd1, 5'd0, 12'd2));
    expectReg(5'd1, 32'd1);
    runProgram("ebreak");
    checkFlags("ebreak", 1'b1, 1'b0);
    checkExpected("ebreak");
    clearProgram();
    appendInstr(encodeAddi(5'd2, 5'd0, 12'd3));
    appendInstr(32'h0000_0000);
    appendInstr(encodeAddi(5'd2, 5'd0, 12'd4));
    appendInstr(EbreakInstr);
    expectReg(5'd2, 32'd3);
    runProgram("illegal");
    checkFlags("illegal", 1'b1, 1'b1);
    checkExpected("illegal");
  endtask

  initial begin
    reset      <= 1'b1;
    progWrite  <= 1'b0;
    progAddr   <= '0;
    progData   <= 32'd0;
    start      <= 1'b0;
    dbgRegAddr <= 5'd0;
    errorCount = 0;
    checkCount = 0;
    lcgState   = Seed;
    testResetIdle();
    testArithmetic();
    testMemory();
    testControlFlow();
    testHalting();
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/core_assertions.sv
`timescale 1ns/10ps

`default_nettype none

module coreAssertions
  import isaPkg::*;
(
  input wire logic       clk,
  input wire logic       reset,
  input wire logic       start,
  input wire logic       running,
  input wire logic       halted,
  input wire logic       memAccess,
  input wire logic [2:0] memOp,
  input wire logic [1:0] addrLow
);

  // ********************************************************************
  // run state rules.
  // ********************************************************************
  resetIdle: assert property (@(posedge clk) reset |=> (!halted && !running))
    else $error("core is running or halted in the cycle after reset");

  haltRunExclusive: assert property (@(posedge clk) !(halted && running))
    else $error("halted and running are both high");

  // only start or reset may release a halted core.
  haltHolds: assert property (@(posedge clk) (halted && !start && !reset) |=> halted)
    else $error("halted dropped without a start");

  // ********************************************************************
  // data memory alignment.
  // ********************************************************************
  wordAligned: assert property (@(posedge clk)
      (memAccess && memOp == memWord) |-> (addrLow == 2'b00))
    else $error("word access to an address that is not word aligned");

  halfAligned: assert property (@(posedge clk)
      (memAccess && (memOp == memHalf || memOp == memHalfU)) |-> !addrLow[0])
    else $error("half access to an odd address");

endmodule

bind fetchUnit coreAssertions fetchChecks (
  .clk(clk), .reset(reset), .start(start), .running(running), .halted(halted),
  .memAccess(1'b0), .memOp(3'b010), .addrLow(2'b00)
);

bind memoryUnit coreAssertions memoryChecks (
  .clk(clk), .reset(1'b0), .start(1'b0), .running(running), .halted(1'b0),
  .memAccess(running && (ctrl.memRead || ctrl.memWrite)), .memOp(ctrl.memOp),
  .addrLow(exec.aluOut[1:0])
);

`default_nettype wire

//--- verilog/core.sv
`timescale 1ns/10ps
`include "core_settings.svh"

`default_nettype none

module core
  import corePkg::*;
(
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire logic                           progWrite,
  input  wire logic [$clog2(`IMEM_WORDS)-1:0] progAddr,
  input  wire logic [31:0]                    progData,
  input  wire logic                           start,
  input  wire logic [4:0]                     dbgRegAddr,
  output      logic                           halted,
  output      logic                           fault,
  output      logic [`XLEN-1:0]               dbgRegData
);

  logic [`XLEN-1:0] pc;
  logic [31:0]      instr;
  logic [`XLEN-1:0] nextPc;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] rs1Data;
  logic [`XLEN-1:0] rs2Data;
  logic [`XLEN-1:0] wbData;
  logic             running;
  ctrlT             ctrl;
  execResultT       exec;

  fetchUnit fetch (
    .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
    .progData(progData), .start(start), .haltReq(ctrl.halt), .illegal(ctrl.illegal),
    .nextPc(nextPc), .pc(pc), .instr(instr), .running(running), .halted(halted),
    .fault(fault)
  );

  decoder decode (.instr(instr), .ctrl(ctrl), .imm(imm));

  // register writes only land while the core runs.
  regFile regs (
    .clk(clk), .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]), .rdAddr(instr[11:7]),
    .writeEnable(ctrl.regWrite && running), .writeData(wbData), .dbgAddr(dbgRegAddr),
    .rs1Data(rs1Data), .rs2Data(rs2Data), .dbgData(dbgRegData)
  );

  executeUnit execute (
    .pc(pc), .imm(imm), .rs1Data(rs1Data), .rs2Data(rs2Data), .ctrl(ctrl),
    .exec(exec), .nextPc(nextPc)
  );

  memoryUnit memory (
    .clk(clk), .running(running), .ctrl(ctrl), .exec(exec), .wbData(wbData)
  );

endmodule

`default_nettype wire

//--- verilog/memoryUnit.sv
`timescale 1ns/10ps
`include "core_settings.svh"

`default_nettype none

module memoryUnit
  import isaPkg::*, corePkg::*;
(
  input  wire logic             clk,
  input  wire logic             running,
  input  wire ctrlT             ctrl,
  input  wire execResultT       exec,
  output      logic [`XLEN-1:0] wbData
);

  localparam int DmemAw = $clog2(`DMEM_WORDS);

  logic [31:0]       dmem [`DMEM_WORDS];
  logic [DmemAw-1:0] wordAddr;
  logic [1:0]        lane;
  logic [3:0]        wrMask;
  logic [31:0]       wrData;
  logic [31:0]       rdShifted;
  logic [`XLEN-1:0]  loadData;

  // address wraps modulo the memory depth.
  assign wordAddr = exec.aluOut[DmemAw+1:2];
  assign lane     = exec.aluOut[1:0];

  // ********************************************************************
  // store path.
  // ********************************************************************
  always_comb begin
    case (ctrl.memOp)
      memByte: begin
        wrMask = 4'b0001 << lane;
        wrData = {4{exec.storeData[7:0]}};
      end
      memHalf: begin
        wrMask = 4'b0011 << {lane[1], 1'b0};
        wrData = {2{exec.storeData[15:0]}};
      end
      memWord: begin
        wrMask = 4'b1111;
        wrData = exec.storeData;
      end
      default: begin
        wrMask = 4'b0000;
        wrData = exec.storeData;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (running && ctrl.memWrite) begin
      for (int i = 0; i < 4; i++) begin
        if (wrMask[i]) dmem[wordAddr][i*8 +: 8] <= wrData[i*8 +: 8];
      end
    end
  end

  // ********************************************************************
  // load path.
  // ********************************************************************
  assign rdShifted = dmem[wordAddr] >> {lane, 3'b000};

  always_comb begin
    case (ctrl.memOp)
      memByte:  loadData = {{24{rdShifted[7]}}, rdShifted[7:0]};
      memHalf:  loadData = {{16{rdShifted[15]}}, rdShifted[15:0]};
      memByteU: loadData = {24'b0, rdShifted[7:0]};
      memHalfU: loadData = {16'b0, rdShifted[15:0]};
      default:  loadData = rdShifted;
    endcase
  end

  assign wbData = ctrl.memRead ? loadData : exec.aluOut;

endmodule

`default_nettype wire

//--- verilog/executeUnit.sv
`timescale 1ns/10ps
`include "core_settings.svh"

`default_nettype none

module executeUnit
  import isaPkg::*, corePkg::*;
(
  input  wire logic [`XLEN-1:0] pc,
  input  wire logic [`XLEN-1:0] imm,
  input  wire logic [`XLEN-1:0] rs1Data,
  input  wire logic [`XLEN-1:0] rs2Data,
  input  wire ctrlT             ctrl,
  output      execResultT       exec,
  output      logic [`XLEN-1:0] nextPc
);

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] aluOut;
  logic [`XLEN-1:0] pcBase;
  logic [`XLEN-1:0] pcOff;
  logic [`XLEN-1:0] pcSum;
  logic [4:0]       shamt;

  // ********************************************************************
  // operand select and alu.
  // ********************************************************************
  always_comb begin
    case (ctrl.aSel)
      aSelPc:   opA = pc;
      aSelZero: opA = '0;
      default:  opA = rs1Data;
    endcase
    case (ctrl.bSel)
      bSelImm:  opB = imm;
      bSelFour: opB = `XLEN'd4;
      default:  opB = rs2Data;
    endcase
  end

  assign shamt = opB[4:0];

  always_comb begin
    case (ctrl.aluOp)
      aluSub:   aluOut = opA - opB;
      aluSll:   aluOut = opA << shamt;
      aluSlt:   aluOut = `XLEN'($signed(opA) < $signed(opB));
      aluSltu:  aluOut = `XLEN'(opA < opB);
      aluXor:   aluOut = opA ^ opB;
      aluSrl:   aluOut = opA >> shamt;
      aluSra:   aluOut = $unsigned($signed(opA) >>> shamt);
      aluOr:    aluOut = opA | opB;
      aluAnd:   aluOut = opA & opB;
      aluEq:    aluOut = `XLEN'(opA == opB);
      aluNe:    aluOut = `XLEN'(opA != opB);
      aluGe:    aluOut = `XLEN'($signed(opA) >= $signed(opB));
      aluGeu:   aluOut = `XLEN'(opA >= opB);
      aluCopyB: aluOut = opB;
      default:  aluOut = opA + opB;
    endcase
  end

  assign exec.aluOut    = aluOut;
  assign exec.storeData = rs2Data;

  // ********************************************************************
  // next pc.
  // ********************************************************************
  assign pcBase = (ctrl.pcBase == pcBaseRs1) ? rs1Data : pc;
  assign pcOff  = (ctrl.pcOff == pcOffImm) ? imm : `XLEN'd4;
  assign pcSum  = pcBase + pcOff;

  always_comb begin
    if (ctrl.isBranch && (aluOut == `XLEN'd1)) begin
      nextPc = pc + imm;
    end else if (ctrl.pcBase == pcBaseRs1) begin
      // jalr clears the target lsb.
      nextPc = {pcSum[`XLEN-1:1], 1'b0};
    end else begin
      nextPc = pcSum;
    end
  end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/10ps
`include "core_settings.svh"

`default_nettype none

module regFile (
  input  wire logic                 clk,
  input  wire logic [4:0]           rs1Addr,
  input  wire logic [4:0]           rs2Addr,
  input  wire logic [4:0]           rdAddr,
  input  wire logic                 writeEnable,
  input  wire logic [`XLEN-1:0]     writeData,
  input  wire logic [4:0]           dbgAddr,
  output      logic [`XLEN-1:0]     rs1Data,
  output      logic [`XLEN-1:0]     rs2Data,
  output      logic [`XLEN-1:0]     dbgData
);

  logic [`XLEN-1:0] regs [32];

  // x0 is hardwired to zero.
  function automatic logic [`XLEN-1:0] readReg(input logic [4:0] addr);
    return (addr == 5'd0) ? '0 : regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (writeEnable && (rdAddr != 5'd0)) regs[rdAddr] <= writeData;
  end

  assign rs1Data = readReg(rs1Addr);
  assign rs2Data = readReg(rs2Addr);
  assign dbgData = readReg(dbgAddr);

endmodule

`default_nettype wire

//--- verilog/fetchUnit.sv
`timescale 1ns/10ps
`include "core_settings.svh"

`default_nettype none

module fetchUnit (
  input  wire logic                             clk,
  input  wire logic                             reset,
  input  wire logic                             progWrite,
  input  wire logic [$clog2(`IMEM_WORDS)-1:0]   progAddr,
  input  wire logic [31:0]                      progData,
  input  wire logic                             start,
  input  wire logic                             haltReq,
  input  wire logic                             illegal,
  input  wire logic [`XLEN-1:0]                 nextPc,
  output      logic [`XLEN-1:0]                 pc,
  output      logic [31:0]                      instr,
  output      logic                             running,
  output      logic                             halted,
  output      logic                             fault
);

  localparam int ImemAw = $clog2(`IMEM_WORDS);

  logic [31:0] imem [`IMEM_WORDS];

  // ********************************************************************
  // pc and run state.
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= `RESET_PC;
      running <= 1'b0;
      halted  <= 1'b0;
      fault   <= 1'b0;
    end else if (start) begin
      pc      <= `RESET_PC;
      running <= 1'b1;
      halted  <= 1'b0;
      fault   <= 1'b0;
    end else if (running) begin
      if (haltReq || illegal) begin
        // the stopping instruction retires and pc stays on it.
        running <= 1'b0;
        halted  <= 1'b1;
        fault   <= illegal;
      end else begin
        pc <= nextPc;
      end
    end
  end

  // the program load port is locked out during a run.
  always_ff @(posedge clk) begin
    if (progWrite && !running) imem[progAddr] <= progData;
  end

  assign instr = imem[pc[ImemAw+1:2]];

endmodule

`default_nettype wire

//--- verilog/decoder.sv
`timescale 1ns/10ps
`include "core_settings.svh"

`default_nettype none

module decoder
  import isaPkg::*, corePkg::*;
(
  input  wire logic [31:0]      instr,
  output      ctrlT             ctrl,
  output      logic [`XLEN-1:0] imm
);

  logic [2:0] funct3;
  logic       funct7Alt;

  assign funct3    = instr[14:12];
  assign funct7Alt = instr[30];

  // funct3 to alu op for op and op-imm.
  function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? aluSub : aluAdd;
      3'b001:  return aluSll;
      3'b010:  return aluSlt;
      3'b011:  return aluSltu;
      3'b100:  return aluXor;
      3'b101:  return alt ? aluSra : aluSrl;
      3'b110:  return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  always_comb begin
    ctrl = '{aluOp: aluAdd, aSel: aSelRs1, bSel: bSelImm, pcBase: pcBasePc,
             pcOff: pcOffFour, memOp: memWord, default: 1'b0};
    imm  = {{20{instr[31]}}, instr[31:20]};

    case (instr[6:0])
      opcLui: begin
        ctrl.aSel     = aSelZero;
        ctrl.aluOp    = aluCopyB;
        ctrl.regWrite = 1'b1;
        imm           = {instr[31:12], 12'b0};
      end
      opcAuipc: begin
        ctrl.aSel     = aSelPc;
        ctrl.regWrite = 1'b1;
        imm           = {instr[31:12], 12'b0};
      end
      // jumps link pc+4 through the alu.
      opcJal: begin
        ctrl.aSel     = aSelPc;
        ctrl.bSel     = bSelFour;
        ctrl.pcOff    = pcOffImm;
        ctrl.regWrite = 1'b1;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      opcJalr: begin
        ctrl.aSel     = aSelPc;
        ctrl.bSel     = bSelFour;
        ctrl.pcBase   = pcBaseRs1;
        ctrl.pcOff    = pcOffImm;
        ctrl.regWrite = 1'b1;
      end
      opcBranch: begin
        ctrl.bSel     = bSelRs2;
        ctrl.isBranch = 1'b1;
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        case (funct3)
          3'b000:  ctrl.aluOp = aluEq;
          3'b001:  ctrl.aluOp = aluNe;
          3'b100:  ctrl.aluOp = aluSlt;
          3'b101:  ctrl.aluOp = aluGe;
          3'b110:  ctrl.aluOp = aluSltu;
          3'b111:  ctrl.aluOp = aluGeu;
          default: begin
            ctrl.isBranch = 1'b0;
            ctrl.illegal  = 1'b1;
          end
        endcase
      end
      opcLoad: begin
        ctrl.memRead  = 1'b1;
        ctrl.memOp    = memOpT'(funct3);
        ctrl.regWrite = 1'b1;
      end
      opcStore: begin
        ctrl.memWrite = 1'b1;
        ctrl.memOp    = memOpT'(funct3);
        imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      // bit 30 is part of the immediate except for srai.
      opcOpImm: begin
        ctrl.aluOp    = aluFromFunct(funct3, funct7Alt && (funct3 == 3'b101));
        ctrl.regWrite = 1'b1;
      end
      opcOp: begin
        ctrl.bSel     = bSelRs2;
        ctrl.aluOp    = aluFromFunct(funct3, funct7Alt);
        ctrl.regWrite = 1'b1;
      end
      opcSystem: begin
        if (instr == EbreakInstr) ctrl.halt = 1'b1;
        else ctrl.illegal = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/corePkg.sv
`include "core_settings.svh"

`default_nettype none

package corePkg;

  import isaPkg::*;

  typedef enum logic [1:0] {aSelRs1, aSelPc, aSelZero} aSelT;
  typedef enum logic [1:0] {bSelRs2, bSelImm, bSelFour} bSelT;
  typedef enum logic {pcBasePc, pcBaseRs1} pcBaseT;
  typedef enum logic {pcOffFour, pcOffImm} pcOffT;

  // decoded control bundle for one instruction.
  typedef struct packed {
    aluOpT  aluOp;
    aSelT   aSel;
    bSelT   bSel;
    pcBaseT pcBase;
    pcOffT  pcOff;
    logic   isBranch;
    logic   memRead;
    logic   memWrite;
    memOpT  memOp;
    logic   regWrite;
    logic   halt;
    logic   illegal;
  } ctrlT;

  // alu result doubles as the data memory address.
  typedef struct packed {
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] storeData;
  } execResultT;

endpackage

`default_nettype wire

//--- verilog/isaPkg.sv
`default_nettype none

package isaPkg;

  // ********************************************************************
  // rv32i major opcodes.
  // ********************************************************************
  typedef enum logic [6:0] {
    opcLui    = 7'b0110111,
    opcAuipc  = 7'b0010111,
    opcJal    = 7'b1101111,
    opcJalr   = 7'b1100111,
    opcBranch = 7'b1100011,
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcOpImm  = 7'b0010011,
    opcOp     = 7'b0110011,
    opcSystem = 7'b1110011
  } opcodeT;

  // alu operations where compares return 1 or 0.
  typedef enum logic [3:0] {
    aluAdd   = 4'd0,
    aluSub   = 4'd1,
    aluSll   = 4'd2,
    aluSlt   = 4'd3,
    aluSltu  = 4'd4,
    aluXor   = 4'd5,
    aluSrl   = 4'd6,
    aluSra   = 4'd7,
    aluOr    = 4'd8,
    aluAnd   = 4'd9,
    aluEq    = 4'd10,
    aluNe    = 4'd11,
    aluGe    = 4'd12,
    aluGeu   = 4'd13,
    aluCopyB = 4'd14
  } aluOpT;

  // access width with the same encoding as funct3 of loads and stores.
  typedef enum logic [2:0] {
    memByte  = 3'b000,
    memHalf  = 3'b001,
    memWord  = 3'b010,
    memByteU = 3'b100,
    memHalfU = 3'b101
  } memOpT;

  // the only system instruction kept.
  localparam logic [31:0] EbreakInstr = 32'h00100073;

endpackage

`default_nettype wire

//--- verilog/core_settings.svh
`default_nettype none

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ********************************************************************
// core dimensions.
// ********************************************************************

// data and address width.
`define XLEN 32

// pc loaded at reset and on start.
`define RESET_PC 32'h80000000

// instruction and data memory depths in words.
`define IMEM_WORDS 256
`define DMEM_WORDS 256

`endif

`default_nettype wire
